// File: gem_csc_config.svh
`ifndef GEM_CSC_CONFIG_SVH
`define GEM_CSC_CONFIG_SVH

// gem side widths
`define GEM_RAW_BITS      14
`define ROLL_BITS         3
`define PAD_BITS          8
`define SIZE_BITS         3

// matching window fields
`define DELTAHS_BITS      5
`define DELTAWIRE_BITS    3

// csc side widths and limits
`define MXXKYB            10
`define WIREBITS          7
`define MAXWIRE           47
`define MINKEYME1B        0
`define MAXKEYME1B        511
`define MINKEYME1A        512
`define MAXKEYME1A        895

// table geometry
`define PAD_COUNT         192
`define MAXPAD            191
`define ROLL_COUNT        8
// only roll 7 reaches into me1a
`define ME1A_ROLL         7
`define WG_PER_ROLL       6
`define PAD_XKY_STEP      2
`define ME1B_XKY_OFFSET   64

// result buffer and credits
`define WINDOW_FIFO_DEPTH 8
`define FIFO_PTR_BITS     3
`define CREDIT_BITS       4

`endif

// File: gem_csc_pkg.sv
`include "gem_csc_config.svh"

package gem_csc_pkg;

  // one gem cluster as delivered by the optical link
  typedef struct packed {
    logic [`GEM_RAW_BITS-1:0] raw;
    logic                     vpf;
    logic [`ROLL_BITS-1:0]    roll;
    // first pad of the cluster, 0 to 191
    logic [`PAD_BITS-1:0]     pad;
    // extra pads beyond the first one
    logic [`SIZE_BITS-1:0]    size;
  } gem_cluster_t;

  // static matching setup, only changed while idle
  typedef struct packed {
    logic                       evenchamber;
    logic                       match_enable;
    logic                       me1a_enable;
    logic                       me1b_enable;
    // window in half-strips
    logic [`DELTAHS_BITS-1:0]   deltahs;
    // window in wiregroups
    logic [`DELTAWIRE_BITS-1:0] deltawire;
  } match_cfg_t;

  // csc station part a cluster is matched to
  typedef enum logic {
    REGION_ME1B = 1'b0,
    REGION_ME1A = 1'b1
  } csc_region_e;

  // translated cluster, ranges already widened
  typedef struct packed {
    logic [`GEM_RAW_BITS-1:0] raw;
    logic                     vpf;
    csc_region_e              region;
    logic [`WIREBITS-1:0]     wire_lo;
    logic [`WIREBITS-1:0]     wire_hi;
    logic [`WIREBITS-1:0]     wire_mi;
    logic [`MXXKYB-1:0]       xky_lo;
    logic [`MXXKYB-1:0]       xky_hi;
    logic [`MXXKYB-1:0]       xky_mi;
  } csc_window_t;

endpackage

// File: pad_xky_rom.sv
`include "gem_csc_config.svh"

module pad_xky_rom #(
  parameter bit IS_ME1A = 1'b0,
  parameter bit IS_ODD  = 1'b0
) (
  input  logic                 logic_clock,
  input  logic [`PAD_BITS-1:0] adr0,
  input  logic [`PAD_BITS-1:0] adr1,
  output logic [`MXXKYB-1:0]   rd0,
  output logic [`MXXKYB-1:0]   rd1
);

  // even chambers count up from the region base
  localparam int EVEN_BASE = IS_ME1A ? `MINKEYME1A : `ME1B_XKY_OFFSET;
  // odd chambers are mirrored, count down from the top
  localparam int ODD_TOP = IS_ME1A ? `MAXKEYME1A :
                           (`ME1B_XKY_OFFSET + `PAD_XKY_STEP * `MAXPAD + 1);

  logic [`MXXKYB-1:0] xky_table [`PAD_COUNT];

  // constant table, built from chamber geometry
  for (genvar p = 0; p < `PAD_COUNT; p++) begin : g_fill
    if (IS_ODD) begin : g_odd
      assign xky_table[p] = `MXXKYB'(ODD_TOP - `PAD_XKY_STEP * p);
    end else begin : g_even
      assign xky_table[p] = `MXXKYB'(EVEN_BASE + `PAD_XKY_STEP * p);
    end
  end

  // two read ports, one cycle latency
  always_ff @(posedge logic_clock) begin
    rd0 <= xky_table[adr0];
    rd1 <= xky_table[adr1];
  end

  // pads above 191 do not exist, the translator has to clamp
  a_adr_in_range: assert property (@(posedge logic_clock)
    (adr0 <= `MAXPAD) && (adr1 <= `MAXPAD));

endmodule

// File: roll_wire_rom.sv
`include "gem_csc_config.svh"

module roll_wire_rom #(
  parameter bit IS_MAX = 1'b0,
  parameter bit IS_ODD = 1'b0
) (
  input  logic                  logic_clock,
  input  logic [`ROLL_BITS-1:0] adr,
  output logic [`WIREBITS-1:0]  rd
);

  // offset of this bound inside one roll band
  localparam int BAND_OFFSET = IS_MAX ? (`WG_PER_ROLL - 1) : 0;

  logic [`WIREBITS-1:0] wire_table [`ROLL_COUNT];

  for (genvar r = 0; r < `ROLL_COUNT; r++) begin : g_fill
    if (IS_ODD) begin : g_odd
      // odd chamber, roll 0 sits at the top wiregroups
      assign wire_table[r] = `WIREBITS'(`MAXWIRE - (`WG_PER_ROLL - 1) - `WG_PER_ROLL * r
                                        + BAND_OFFSET);
    end else begin : g_even
      assign wire_table[r] = `WIREBITS'(`WG_PER_ROLL * r + BAND_OFFSET);
    end
  end

  // registered read
  always_ff @(posedge logic_clock) begin
    rd <= wire_table[adr];
  end

endmodule

// File: cluster_window_calc.sv
`include "gem_csc_config.svh"

module cluster_window_calc (
  input  logic                      logic_clock,
  input  logic                      rst,
  input  gem_csc_pkg::match_cfg_t   cfg,
  input  gem_csc_pkg::gem_cluster_t cluster_in,
  input  logic                      cluster_push,
  output gem_csc_pkg::csc_window_t  result,
  output logic                      result_push
);

  import gem_csc_pkg::*;

  // stage 1 addressing
  logic [`PAD_BITS:0]       pad_sum;
  logic [`PAD_BITS-1:0]     pad_lo;
  logic [`PAD_BITS-1:0]     pad_hi;
  logic                     is_me1a;

  // stage 1 registers, aligned with the rom outputs
  logic                     s1_push;
  logic [`GEM_RAW_BITS-1:0] s1_raw;
  logic                     s1_vpf;
  csc_region_e              s1_region;

  // rom outputs
  logic [`MXXKYB-1:0]       me1a_even_lo;
  logic [`MXXKYB-1:0]       me1a_even_hi;
  logic [`MXXKYB-1:0]       me1a_odd_lo;
  logic [`MXXKYB-1:0]       me1a_odd_hi;
  logic [`MXXKYB-1:0]       me1b_even_lo;
  logic [`MXXKYB-1:0]       me1b_even_hi;
  logic [`MXXKYB-1:0]       me1b_odd_lo;
  logic [`MXXKYB-1:0]       me1b_odd_hi;
  logic [`WIREBITS-1:0]     wg_min_even;
  logic [`WIREBITS-1:0]     wg_max_even;
  logic [`WIREBITS-1:0]     wg_min_odd;
  logic [`WIREBITS-1:0]     wg_max_odd;

  // stage 2 window math
  logic [`MXXKYB-1:0]       xky_a;
  logic [`MXXKYB-1:0]       xky_b;
  logic [`MXXKYB-1:0]       key_min;
  logic [`MXXKYB-1:0]       key_max;
  logic [`MXXKYB-1:0]       xky_real_lo;
  logic [`MXXKYB-1:0]       xky_real_hi;
  logic [`MXXKYB:0]         xky_hi_sum;
  logic [6:0]               deltaxky;
  logic [`WIREBITS-1:0]     wire_a;
  logic [`WIREBITS-1:0]     wire_b;
  logic [`WIREBITS-1:0]     wire_real_lo;
  logic [`WIREBITS-1:0]     wire_real_hi;
  logic [`WIREBITS:0]       wire_hi_sum;

  // last pad of the cluster, kept inside the chamber
  assign pad_sum = cluster_in.pad + cluster_in.size;
  // invalid clusters look up pad 0 on both ports
  assign pad_lo  = cluster_in.vpf ? cluster_in.pad : '0;
  assign pad_hi  = !cluster_in.vpf ? '0 :
                   (pad_sum > `MAXPAD) ? `PAD_BITS'(`MAXPAD) : pad_sum[`PAD_BITS-1:0];
  assign is_me1a = (cluster_in.roll == `ROLL_BITS'(`ME1A_ROLL)) && cfg.me1a_enable;

  pad_xky_rom #(.IS_ME1A(1'b1), .IS_ODD(1'b0)) u_me1a_even (
    .logic_clock(logic_clock), .adr0(pad_lo), .adr1(pad_hi),
    .rd0(me1a_even_lo), .rd1(me1a_even_hi)
  );
  pad_xky_rom #(.IS_ME1A(1'b1), .IS_ODD(1'b1)) u_me1a_odd (
    .logic_clock(logic_clock), .adr0(pad_lo), .adr1(pad_hi),
    .rd0(me1a_odd_lo), .rd1(me1a_odd_hi)
  );
  pad_xky_rom #(.IS_ME1A(1'b0), .IS_ODD(1'b0)) u_me1b_even (
    .logic_clock(logic_clock), .adr0(pad_lo), .adr1(pad_hi),
    .rd0(me1b_even_lo), .rd1(me1b_even_hi)
  );
  pad_xky_rom #(.IS_ME1A(1'b0), .IS_ODD(1'b1)) u_me1b_odd (
    .logic_clock(logic_clock), .adr0(pad_lo), .adr1(pad_hi),
    .rd0(me1b_odd_lo), .rd1(me1b_odd_hi)
  );

  // roll to wiregroup band, both bounds and both parities
  roll_wire_rom #(.IS_MAX(1'b0), .IS_ODD(1'b0)) u_wg_min_even (
    .logic_clock(logic_clock), .adr(cluster_in.roll), .rd(wg_min_even)
  );
  roll_wire_rom #(.IS_MAX(1'b1), .IS_ODD(1'b0)) u_wg_max_even (
    .logic_clock(logic_clock), .adr(cluster_in.roll), .rd(wg_max_even)
  );
  roll_wire_rom #(.IS_MAX(1'b0), .IS_ODD(1'b1)) u_wg_min_odd (
    .logic_clock(logic_clock), .adr(cluster_in.roll), .rd(wg_min_odd)
  );
  roll_wire_rom #(.IS_MAX(1'b1), .IS_ODD(1'b1)) u_wg_max_odd (
    .logic_clock(logic_clock), .adr(cluster_in.roll), .rd(wg_max_odd)
  );

  // side info travels with the rom read
  always_ff @(posedge logic_clock) begin
    s1_raw    <= cluster_in.raw;
    s1_region <= is_me1a ? REGION_ME1A : REGION_ME1B;
    s1_vpf    <= cluster_in.vpf && cfg.match_enable && (cfg.me1b_enable || is_me1a);
  end

  always_ff @(posedge logic_clock) begin
    if (rst) begin
      s1_push <= 1'b0;
    end else begin
      s1_push <= cluster_push;
    end
  end

  // pick table by region and parity, region sets the clamp limits
  always_comb begin
    if (s1_region == REGION_ME1A) begin
      xky_a   = cfg.evenchamber ? me1a_even_lo : me1a_odd_lo;
      xky_b   = cfg.evenchamber ? me1a_even_hi : me1a_odd_hi;
      key_min = `MXXKYB'(`MINKEYME1A);
      key_max = `MXXKYB'(`MAXKEYME1A);
    end else begin
      xky_a   = cfg.evenchamber ? me1b_even_lo : me1b_odd_lo;
      xky_b   = cfg.evenchamber ? me1b_even_hi : me1b_odd_hi;
      key_min = `MXXKYB'(`MINKEYME1B);
      key_max = `MXXKYB'(`MAXKEYME1B);
    end
  end

  assign wire_a = cfg.evenchamber ? wg_min_even : wg_min_odd;
  assign wire_b = cfg.evenchamber ? wg_max_even : wg_max_odd;

  // odd strip order runs backwards, put ends in order
  assign xky_real_lo  = (xky_a < xky_b) ? xky_a : xky_b;
  assign xky_real_hi  = (xky_a < xky_b) ? xky_b : xky_a;
  assign wire_real_lo = (wire_a < wire_b) ? wire_a : wire_b;
  assign wire_real_hi = (wire_a < wire_b) ? wire_b : wire_a;

  // half-strip window to eighth-strip units
  assign deltaxky    = {cfg.deltahs, 2'b00};
  assign xky_hi_sum  = xky_real_hi + deltaxky;
  assign wire_hi_sum = wire_real_hi + cfg.deltawire;

  // widen, clamp at chamber edges, register
  always_ff @(posedge logic_clock) begin
    result.raw     <= s1_raw;
    result.vpf     <= s1_vpf;
    result.region  <= s1_region;
    result.xky_lo  <= (xky_real_lo > key_min + deltaxky) ? xky_real_lo - deltaxky : key_min;
    result.xky_hi  <= (xky_hi_sum > key_max) ? key_max : xky_hi_sum[`MXXKYB-1:0];
    result.xky_mi  <= xky_real_lo[`MXXKYB-1:1] + xky_real_hi[`MXXKYB-1:1]
                      + (xky_real_lo[0] | xky_real_hi[0]);
    result.wire_lo <= (wire_real_lo > cfg.deltawire) ? wire_real_lo - cfg.deltawire : '0;
    result.wire_hi <= (wire_hi_sum < `MAXWIRE) ? wire_hi_sum[`WIREBITS-1:0]
                                               : `WIREBITS'(`MAXWIRE);
    result.wire_mi <= wire_real_lo[`WIREBITS-1:1] + wire_real_hi[`WIREBITS-1:1]
                      + (wire_real_lo[0] | wire_real_hi[0]);
  end

  always_ff @(posedge logic_clock) begin
    if (rst) begin
      result_push <= 1'b0;
    end else begin
      result_push <= s1_push;
    end
  end

  // ordering must survive the widening for both parities
  a_wire_ordered: assert property (@(posedge logic_clock) disable iff (rst)
    result_push |-> result.wire_lo <= result.wire_hi);
  a_xky_ordered: assert property (@(posedge logic_clock) disable iff (rst)
    result_push |-> result.xky_lo <= result.xky_hi);

endmodule

// File: window_credit_fifo.sv
`include "gem_csc_config.svh"

module window_credit_fifo (
  input  logic                     logic_clock,
  input  logic                     rst,
  input  gem_csc_pkg::csc_window_t result,
  input  logic                     result_push,
  input  logic                     window_credit,
  output gem_csc_pkg::csc_window_t window_out,
  output logic                     window_valid,
  output logic                     cluster_credit
);

  import gem_csc_pkg::*;

  localparam int DEPTH = `WINDOW_FIFO_DEPTH;

  // storage, no reset on payload
  csc_window_t               mem [DEPTH];
  logic [`FIFO_PTR_BITS-1:0] wr_ptr;
  logic [`FIFO_PTR_BITS-1:0] rd_ptr;
  logic [`CREDIT_BITS-1:0]   fill_cnt;
  // credits granted by the csc matcher
  logic [`CREDIT_BITS-1:0]   credit_cnt;
  logic                      empty;
  logic                      full;
  logic                      send;

  assign empty = (fill_cnt == '0);
  assign full  = (fill_cnt == `CREDIT_BITS'(DEPTH));
  // head leaves when something is queued and a credit is held
  assign send  = !empty && (credit_cnt != '0);

  assign window_valid   = send;
  assign window_out     = mem[rd_ptr];
  // freed slot goes back upstream in the same cycle
  assign cluster_credit = send;

  always_ff @(posedge logic_clock) begin
    if (result_push) begin
      mem[wr_ptr] <= result;
    end
  end

  always_ff @(posedge logic_clock) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_cnt   <= '0;
      credit_cnt <= '0;
    end else begin
      // pointers wrap naturally, depth is a power of two
      if (result_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({result_push, send})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
      // grant and send together cancel out
      case ({window_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // upstream credit loop keeps the buffer from overflowing
  a_no_overflow: assert property (@(posedge logic_clock) disable iff (rst)
    !(result_push && full));
  // sink never grants more than the buffer holds
  a_credit_bound: assert property (@(posedge logic_clock) disable iff (rst)
    credit_cnt <= DEPTH);

endmodule

// File: gem_csc_cluster_top.sv
module gem_csc_cluster_top (
  input  logic                      logic_clock,
  input  logic                      rst,
  input  gem_csc_pkg::match_cfg_t   cfg,
  input  gem_csc_pkg::gem_cluster_t cluster_in,
  input  logic                      cluster_push,
  output logic                      cluster_credit,
  output gem_csc_pkg::csc_window_t  window_out,
  output logic                      window_valid,
  input  logic                      window_credit
);

  import gem_csc_pkg::*;

  // translated cluster into the buffer
  csc_window_t result;
  logic        result_push;

  // two stage translation, rom read then window math
  cluster_window_calc u_calc (
    .logic_clock (logic_clock),
    .rst         (rst),
    .cfg         (cfg),
    .cluster_in  (cluster_in),
    .cluster_push(cluster_push),
    .result      (result),
    .result_push (result_push)
  );

  // credit controlled output queue
  window_credit_fifo u_fifo (
    .logic_clock   (logic_clock),
    .rst           (rst),
    .result        (result),
    .result_push   (result_push),
    .window_credit (window_credit),
    .window_out    (window_out),
    .window_valid  (window_valid),
    .cluster_credit(cluster_credit)
  );

endmodule

// File: tb_gem_csc_cluster.sv
`include "gem_csc_config.svh"

module tb_gem_csc_cluster;

  import gem_csc_pkg::*;

  logic         logic_clock = 1'b0;
  logic         rst;
  match_cfg_t   cfg;
  gem_cluster_t cluster_in;
  logic         cluster_push;
  logic         cluster_credit;
  csc_window_t  window_out;
  logic         window_valid;
  logic         window_credit;

  int          seed = 45;
  csc_window_t expected_q[$];
  csc_window_t want;
  // credits the gem source holds
  int          up_credits = `WINDOW_FIFO_DEPTH;
  int          pushed = 0;
  int          received = 0;
  int          credit_returns = 0;
  int          grants = 0;
  int          pending_grants = 0;
  bit          random_grants = 1'b0;
  int          coin;

  gem_csc_cluster_top dut0 (
    .logic_clock   (logic_clock),
    .rst           (rst),
    .cfg           (cfg),
    .cluster_in    (cluster_in),
    .cluster_push  (cluster_push),
    .cluster_credit(cluster_credit),
    .window_out    (window_out),
    .window_valid  (window_valid),
    .window_credit (window_credit)
  );

  always #5 logic_clock = ~logic_clock;

  task automatic stop_with_failure(input string reason);
    $display("error at time %0t: %s", $time, reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input int got, input int exp_val);
    assert (got == exp_val) else begin
      $display("MISMATCH time %0t %s got %0d expected %0d", $time, name, got, exp_val);
      stop_with_failure("window field differs from the model");
    end
  endtask

  // key eighth-strip of one pad from the linear chamber geometry
  function automatic int xky_of_pad(input int p, input bit me1a, input bit even);
    if (me1a) begin
      return even ? 512 + 2 * p : 895 - 2 * p;
    end
    return even ? 64 + 2 * p : 447 - 2 * p;
  endfunction

  // odd chambers are mirrored in wiregroup
  function automatic int wire_of_roll(input int r, input bit is_max, input bit even);
    if (even) begin
      return 6 * r + (is_max ? 5 : 0);
    end
    return is_max ? 47 - 6 * r : 42 - 6 * r;
  endfunction

  function automatic csc_window_t window_model(input gem_cluster_t c, input match_cfg_t k);
    csc_window_t w;
    bit          me1a;
    int          p_lo, p_hi, a, b, lo, hi, kmin, kmax, win;
    me1a = (c.roll == 7) && k.me1a_enable;
    p_lo = c.vpf ? c.pad : 0;
    p_hi = c.vpf ? c.pad + c.size : 0;
    if (p_hi > 191) p_hi = 191;
    a = xky_of_pad(p_lo, me1a, k.evenchamber);
    b = xky_of_pad(p_hi, me1a, k.evenchamber);
    lo = (a < b) ? a : b;
    hi = (a < b) ? b : a;
    kmin = me1a ? 512 : 0;
    kmax = me1a ? 895 : 511;
    win = 4 * k.deltahs;
    w.raw = c.raw;
    w.vpf = c.vpf && k.match_enable && (k.me1b_enable || me1a);
    w.region = me1a ? REGION_ME1A : REGION_ME1B;
    w.xky_lo = `MXXKYB'((lo > kmin + win) ? lo - win : kmin);
    w.xky_hi = `MXXKYB'((hi + win > kmax) ? kmax : hi + win);
    w.xky_mi = `MXXKYB'(lo / 2 + hi / 2 + ((lo | hi) & 1));
    a = wire_of_roll(c.roll, 1'b0, k.evenchamber);
    b = wire_of_roll(c.roll, 1'b1, k.evenchamber);
    lo = (a < b) ? a : b;
    hi = (a < b) ? b : a;
    w.wire_lo = `WIREBITS'((lo > k.deltawire) ? lo - k.deltawire : 0);
    w.wire_hi = `WIREBITS'((hi + k.deltawire < 47) ? hi + k.deltawire : 47);
    w.wire_mi = `WIREBITS'(lo / 2 + hi / 2 + ((lo | hi) & 1));
    return w;
  endfunction

  task automatic compare_window(input csc_window_t got, input csc_window_t exp_w);
    check_field("raw", got.raw, exp_w.raw);
    check_field("vpf", got.vpf, exp_w.vpf);
    check_field("region", int'(got.region), int'(exp_w.region));
    check_field("wire_lo", got.wire_lo, exp_w.wire_lo);
    check_field("wire_hi", got.wire_hi, exp_w.wire_hi);
    check_field("wire_mi", got.wire_mi, exp_w.wire_mi);
    check_field("xky_lo", got.xky_lo, exp_w.xky_lo);
    check_field("xky_hi", got.xky_hi, exp_w.xky_hi);
    check_field("xky_mi", got.xky_mi, exp_w.xky_mi);
  endtask

  // compare process pops one expected result per window_valid cycle
  always @(posedge logic_clock) begin
    if (!rst) begin
      if (cluster_credit) begin
        credit_returns++;
        up_credits++;
      end
      assert (up_credits <= `WINDOW_FIFO_DEPTH) else
        stop_with_failure("more upstream credits returned than buffer slots");
      if (window_valid) begin
        if (expected_q.size() == 0) begin
          stop_with_failure("a result left the buffer with no cluster pending");
        end else begin
          want = expected_q.pop_front();
          compare_window(window_out, want);
          received++;
        end
      end
    end
  end

  // downstream credit schedule drawn on the rising edge and driven on the falling edge
  initial begin
    window_credit = 1'b0;
    forever begin
      @(posedge logic_clock);
      coin = $random(seed);
      @(negedge logic_clock);
      if (pending_grants > 0) begin
        window_credit = 1'b1;
        pending_grants--;
        grants++;
      end else if (random_grants && (coin % 4 != 0)
                   && (grants - received < `WINDOW_FIFO_DEPTH)) begin
        window_credit = 1'b1;
        grants++;
      end else begin
        window_credit = 1'b0;
      end
    end
  end

  task automatic set_cfg(input bit even, input bit match, input bit a_en, input bit b_en,
                         input int dhs, input int dw);
    cfg.evenchamber  = even;
    cfg.match_enable = match;
    cfg.me1a_enable  = a_en;
    cfg.me1b_enable  = b_en;
    cfg.deltahs      = `DELTAHS_BITS'(dhs);
    cfg.deltawire    = `DELTAWIRE_BITS'(dw);
  endtask

  function automatic gem_cluster_t make_cluster(input bit vpf, input int roll, input int pad,
                                                input int size);
    gem_cluster_t c;
    c.raw  = `GEM_RAW_BITS'($random(seed));
    c.vpf  = vpf;
    c.roll = `ROLL_BITS'(roll);
    c.pad  = `PAD_BITS'(pad);
    c.size = `SIZE_BITS'(size);
    return c;
  endfunction

  function automatic gem_cluster_t random_cluster(input bit vpf, input int roll);
    return make_cluster(vpf, roll, $unsigned($random(seed)) % `PAD_COUNT, $random(seed) & 7);
  endfunction

  task automatic push_cluster(input gem_cluster_t c);
    int waited;
    waited = 0;
    @(negedge logic_clock);
    while (up_credits == 0) begin
      cluster_push = 1'b0;
      waited++;
      if (waited > 300) stop_with_failure("no upstream credit came back within 300 cycles");
      @(negedge logic_clock);
    end
    cluster_in   = c;
    cluster_push = 1'b1;
    up_credits--;
    pushed++;
    expected_q.push_back(window_model(c, cfg));
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    @(negedge logic_clock);
    cluster_push = 1'b0;
    while (expected_q.size() != 0) begin
      waited++;
      if (waited > 2000) stop_with_failure("results did not drain within 2000 cycles");
      @(negedge logic_clock);
    end
  endtask

  task automatic wait_received(input int target);
    int waited;
    waited = 0;
    while (received < target) begin
      waited++;
      if (waited > 100) stop_with_failure("granted results did not leave within 100 cycles");
      @(negedge logic_clock);
    end
  endtask

  // nothing may leave and no credit may come back
  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge logic_clock);
      cluster_push = 1'b0;
      assert (!window_valid && !cluster_credit) else
        stop_with_failure("result or upstream credit seen while none may leave");
    end
  endtask

  task automatic set_random_grants(input bit on);
    @(posedge logic_clock);
    random_grants = on;
    @(negedge logic_clock);
  endtask

  // k downstream credits starting at the next falling edge
  task automatic grant_credits(input int k);
    @(posedge logic_clock);
    pending_grants = k;
    @(negedge logic_clock);
  endtask

  initial begin
    int held;
    int base;
    rst          = 1'b1;
    cluster_in   = '0;
    cluster_push = 1'b0;
    set_cfg(1'b1, 1'b1, 1'b1, 1'b1, 0, 0);
    repeat (10) @(negedge logic_clock);
    rst = 1'b0;

    // quiet after reset with no credits granted
    expect_quiet(20);

    // even chamber over every roll with steady credits
    set_cfg(1'b1, 1'b1, 1'b1, 1'b1, $random(seed) & 31, $random(seed) & 7);
    set_random_grants(1'b1);
    for (int i = 0; i < 48; i++) push_cluster(random_cluster(1'b1, i % 8));
    drain_results();

    // edge pads and rolls with the widest windows and the odd chamber first
    for (int par = 0; par < 2; par++) begin
      set_cfg(par == 1, 1'b1, 1'b1, 1'b1, 31, 7);
      push_cluster(make_cluster(1'b1, 0, 0, 0));
      push_cluster(make_cluster(1'b1, 7, 191, 0));
      push_cluster(make_cluster(1'b1, 3, 189, 7));
      push_cluster(make_cluster(1'b1, 7, 0, 7));
      push_cluster(make_cluster(1'b1, 0, 191, 7));
      for (int i = 0; i < 16; i++) push_cluster(random_cluster(1'b1, i % 8));
      drain_results();
    end

    // each enable cleared in turn with invalid clusters mixed in
    for (int g = 0; g < 3; g++) begin
      set_cfg($random(seed) & 1, g != 0, g != 1, g != 2, $random(seed) & 31, $random(seed) & 7);
      for (int i = 0; i < 16; i++) push_cluster(random_cluster($random(seed) & 1, i % 8));
      drain_results();
    end

    // use up credits still held by the buffer before back-pressure
    set_random_grants(1'b0);
    held = grants - received;
    for (int i = 0; i < held; i++) push_cluster(random_cluster(1'b1, i % 8));
    drain_results();
    for (int i = 0; i < `WINDOW_FIFO_DEPTH; i++) push_cluster(random_cluster(1'b1, i));
    expect_quiet(50);
    assert (up_credits == 0) else stop_with_failure("source regained credits while stalled");
    base = received;
    grant_credits(3);
    wait_received(base + 3);
    expect_quiet(20);
    grant_credits(5);
    wait_received(base + 8);

    // long random run with credit accounting
    set_random_grants(1'b1);
    for (int s = 0; s < 4; s++) begin
      set_cfg($random(seed) & 1, 1'b1, $random(seed) & 1, $random(seed) & 1,
              $random(seed) & 31, $random(seed) & 7);
      for (int i = 0; i < 60; i++) begin
        push_cluster(random_cluster($random(seed) & 1, $random(seed) & 7));
        repeat ($unsigned($random(seed)) % 3) begin
          @(negedge logic_clock);
          cluster_push = 1'b0;
        end
      end
      drain_results();
    end

    if ((credit_returns == received) && (received == pushed)
        && (up_credits == `WINDOW_FIFO_DEPTH)) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("credits returned %0d, results %0d, pushed %0d, source credits %0d",
               credit_returns, received, pushed, up_credits);
      stop_with_failure("credit totals do not balance");
    end
  end

endmodule

// File: verilog.f
+incdir+.
gem_csc_pkg.sv
pad_xky_rom.sv
roll_wire_rom.sv
cluster_window_calc.sv
window_credit_fifo.sv
gem_csc_cluster_top.sv
tb_gem_csc_cluster.sv
